/* design/ram_line_reader.sv */
// ====================
// Burst line buffer and read word select
// Capture and buffer-valid come from the controller
// Data is only meaningful while ack is high
// ====================
`timescale 1ns/1ps
`default_nettype none

module ram_line_reader
  import ram_wb_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic [LINE_W-1:0] line_i,
  input  logic              cap_i,
  input  logic              buf_valid_i,
  input  logic [1:0]        word_sel_i,
  output word_t             dat_o
);

  // ====================
  // Burst buffer
  // ====================

  // Whole line kept for the remaining beats
  logic [LINE_W-1:0] buf_q;
  // Line the current beat reads from
  logic [LINE_W-1:0] src_line;

  always_ff @(posedge clk_i) begin
    if (cap_i) begin
      buf_q <= line_i;
    end
  end

  // ====================
  // Word select
  // ====================

  // First beat and single reads use the live bank outputs
  assign src_line = buf_valid_i ? buf_q : line_i;

  always_comb begin
    dat_o = src_line[word_sel_i*WORD_W +: WORD_W];
  end

  // ====================
  // Checks
  // ====================

  // Capturing mid-burst would overwrite the line being served
  a_no_cap_in_burst : assert property (
    @(posedge clk_i) disable iff (!rst_ni) cap_i |-> !buf_valid_i
  );

endmodule

`default_nettype wire

/* design/ram_wb_ctrl.sv */
// ====================
// Wishbone request decode and timing for the line RAM
// Master must hold every request signal until ack
// Bursts stay inside one line and must not mix in writes
// RAM_LATENCY below 2 is rejected at elaboration
// ====================
`timescale 1ns/1ps
`default_nettype none

module ram_wb_ctrl
  import ram_wb_pkg::*;
#(
  parameter int LINE_DEPTH  = 1024,
  parameter int RAM_LATENCY = 16
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          wb_cyc_i,
  input  logic                          wb_stb_i,
  input  logic                          wb_we_i,
  input  ram_addr_u                     wb_adr_i,
  input  word_t                         wb_dat_i,
  input  strb_t                         wb_sel_i,
  input  cti_t                          wb_cti_i,
  output logic                          wb_ack_o,
  output logic [$clog2(LINE_DEPTH)-1:0] bank_idx_o,
  output word_t                         bank_wdata_o,
  output strb_t                         bank_strb_o [LINE_WORDS],
  output logic                          bank_rd_o,
  output logic                          cap_o,
  output logic                          buf_valid_o,
  output logic [1:0]                    word_sel_o
);

  // Counter must reach RAM_LATENCY itself
  localparam int CNT_W = $clog2(RAM_LATENCY + 1);

  if (RAM_LATENCY < 2) begin : gen_bad_latency
    $error("RAM_LATENCY must be at least 2");
  end

  // ====================
  // Request decode
  // ====================
  logic req;
  logic wr_ack;
  logic lat_ack;
  logic buf_ack;

  // Latency tracking
  logic             pend_q;
  logic [CNT_W-1:0] lat_q;

  // Burst state
  logic                             buf_valid_q;
  logic [ADDR_W-1:LINE_OFF_W]       burst_tag_q;

  assign req = wb_cyc_i && wb_stb_i;

  // Line index wraps modulo LINE_DEPTH
  assign bank_idx_o = wb_adr_i.fields.line_addr[$clog2(LINE_DEPTH)-1:0];
  assign word_sel_o = wb_adr_i.fields.word_sel;

  // Same word offered to every bank, strobe picks the lane
  assign bank_wdata_o = wb_dat_i;

  // Byte select goes only to the addressed bank, writes only
  always_comb begin
    for (int i = 0; i < LINE_WORDS; i++) begin
      if (req && wb_we_i && (wb_adr_i.fields.word_sel == 2'(i))) begin
        bank_strb_o[i] = wb_sel_i;
      end else begin
        bank_strb_o[i] = '0;
      end
    end
  end

  // One read strobe per fetch, none while waiting or serving a burst
  assign bank_rd_o = req && !wb_we_i && !pend_q && !buf_valid_q;

  // ====================
  // Latency counter
  // ====================

  // lat_q counts cycles since the strobe edge
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      pend_q <= 1'b0;
      lat_q  <= '0;
    end else if (bank_rd_o) begin
      pend_q <= 1'b1;
      lat_q  <= CNT_W'(1);
    end else if (lat_ack) begin
      pend_q <= 1'b0;
      lat_q  <= '0;
    end else if (pend_q) begin
      lat_q <= lat_q + CNT_W'(1);
    end
  end

  // First read beat done, line now visible on the banks
  assign lat_ack = pend_q && (lat_q == CNT_W'(RAM_LATENCY));

  // ====================
  // Burst state and ack
  // ====================

  // Opened by an INCR first beat, closed by the EOB beat
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      buf_valid_q <= 1'b0;
    end else if (lat_ack && (wb_cti_i == CTI_INCR)) begin
      buf_valid_q <= 1'b1;
    end else if (buf_ack && (wb_cti_i == CTI_EOB)) begin
      buf_valid_q <= 1'b0;
    end
  end

  // Line tag of the captured line, for the burst range check
  always_ff @(posedge clk_i) begin
    if (lat_ack) begin
      burst_tag_q <= wb_adr_i.byte_addr[ADDR_W-1:LINE_OFF_W];
    end
  end

  assign wr_ack  = req && wb_we_i;
  // Later beats served straight from the buffer
  assign buf_ack = buf_valid_q && req && !wb_we_i;

  assign wb_ack_o    = wr_ack || lat_ack || buf_ack;
  assign cap_o       = lat_ack;
  assign buf_valid_o = buf_valid_q;

  // ====================
  // Protocol checks
  // ====================

  // Master must still hold the request when the delayed ack fires
  a_ack_has_req : assert property (
    @(posedge clk_i) disable iff (!rst_ni) wb_ack_o |-> req
  );

  a_no_wr_in_burst : assert property (
    @(posedge clk_i) disable iff (!rst_ni) (buf_valid_q && req) |-> !wb_we_i
  );

  // Buffered beats must hit the line that was fetched
  a_burst_in_line : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (buf_valid_q && req) |-> (wb_adr_i.byte_addr[ADDR_W-1:LINE_OFF_W] == burst_tag_q)
  );

endmodule

`default_nettype wire

/* design/ram_wb_pkg.sv */
// ====================
// Shared widths, cycle-type codes and address decode for the RAM slave
// Line geometry is fixed at four 32-bit words per line
// Address view assumes a 32-bit byte address
// ====================
`default_nettype none

package ram_wb_pkg;

  // ====================
  // Bus and line widths
  // ====================

  // Bus data word
  localparam int WORD_W = 32;
  // Bus byte address
  localparam int ADDR_W = 32;
  // Words per line, also the bank count
  localparam int LINE_WORDS = 4;
  localparam int LINE_W = WORD_W * LINE_WORDS;
  // Byte offset bits inside one line
  localparam int LINE_OFF_W = $clog2(LINE_W / 8);

  typedef logic [WORD_W-1:0] word_t;
  // One bit per byte lane
  typedef logic [WORD_W/8-1:0] strb_t;

  // ====================
  // Wishbone cycle types
  // ====================
  typedef logic [2:0] cti_t;

  localparam cti_t CTI_CLASSIC = 3'b000;
  localparam cti_t CTI_INCR = 3'b010;
  // Last beat of a burst
  localparam cti_t CTI_EOB = 3'b111;

  // ====================
  // Address decode
  // ====================

  // Field view, LSB first from the bottom
  typedef struct packed {
    logic [ADDR_W-LINE_OFF_W-1:0] line_addr;
    logic [1:0]                   word_sel;
    logic [1:0]                   byte_off;
  } ram_addr_fields_t;

  // Same 32 bits seen as raw byte address or as line fields
  typedef union packed {
    logic [ADDR_W-1:0] byte_addr;
    ram_addr_fields_t  fields;
  } ram_addr_u;

endpackage

`default_nettype wire

/* design/ram_wb_top.sv */
// ====================
// Wishbone B4 slave for a cache-line RAM on a 32-bit bus
// Classic handshake only, no err, rty or stall
// LINE_DEPTH must be a power of two, RAM_LATENCY at least 2
// ====================
`timescale 1ns/1ps
`default_nettype none

module ram_wb_top
  import ram_wb_pkg::*;
#(
  parameter int LINE_DEPTH  = 1024,
  parameter int RAM_LATENCY = 16
) (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      wb_cyc_i,
  input  logic      wb_stb_i,
  input  logic      wb_we_i,
  input  ram_addr_u wb_adr_i,
  input  word_t     wb_dat_i,
  input  strb_t     wb_sel_i,
  input  cti_t      wb_cti_i,
  output word_t     wb_dat_o,
  output logic      wb_ack_o
);

  // ====================
  // Internal nets
  // ====================
  logic [$clog2(LINE_DEPTH)-1:0] bank_idx;
  word_t                         bank_wdata;
  strb_t                         bank_strb [LINE_WORDS];
  logic                          bank_rd;
  // Bank words side by side, word 0 at the bottom
  logic [LINE_W-1:0]             bank_line;
  logic                          cap;
  logic                          buf_valid;
  logic [1:0]                    word_sel;

  // ====================
  // Controller
  // ====================
  ram_wb_ctrl #(
    .LINE_DEPTH  (LINE_DEPTH),
    .RAM_LATENCY (RAM_LATENCY)
  ) u_ctrl (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .wb_cyc_i     (wb_cyc_i),
    .wb_stb_i     (wb_stb_i),
    .wb_we_i      (wb_we_i),
    .wb_adr_i     (wb_adr_i),
    .wb_dat_i     (wb_dat_i),
    .wb_sel_i     (wb_sel_i),
    .wb_cti_i     (wb_cti_i),
    .wb_ack_o     (wb_ack_o),
    .bank_idx_o   (bank_idx),
    .bank_wdata_o (bank_wdata),
    .bank_strb_o  (bank_strb),
    .bank_rd_o    (bank_rd),
    .cap_o        (cap),
    .buf_valid_o  (buf_valid),
    .word_sel_o   (word_sel)
  );

  // ====================
  // Word banks
  // ====================

  // All banks share index and read strobe
  for (genvar g = 0; g < LINE_WORDS; g++) begin : gen_bank
    ram_word_bank #(
      .LINE_DEPTH (LINE_DEPTH)
    ) u_bank (
      .clk_i   (clk_i),
      .idx_i   (bank_idx),
      .wdata_i (bank_wdata),
      .strb_i  (bank_strb[g]),
      .rd_i    (bank_rd),
      .rdata_o (bank_line[g*WORD_W +: WORD_W])
    );
  end

  // Read data path
  ram_line_reader u_reader (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .line_i      (bank_line),
    .cap_i       (cap),
    .buf_valid_i (buf_valid),
    .word_sel_i  (word_sel),
    .dat_o       (wb_dat_o)
  );

endmodule

`default_nettype wire

/* design/ram_word_bank.sv */
// ====================
// One 32-bit lane of the line RAM
// Contents are not initialized
// Read data holds until the next read strobe
// ====================
`timescale 1ns/1ps
`default_nettype none

module ram_word_bank
  import ram_wb_pkg::*;
#(
  parameter int LINE_DEPTH = 1024
) (
  input  logic                          clk_i,
  input  logic [$clog2(LINE_DEPTH)-1:0] idx_i,
  input  word_t                         wdata_i,
  input  strb_t                         strb_i,
  input  logic                          rd_i,
  output word_t                         rdata_o
);

  // ====================
  // Storage
  // ====================
  word_t mem [LINE_DEPTH];

  // Byte lanes written independently
  always_ff @(posedge clk_i) begin
    for (int b = 0; b < WORD_W / 8; b++) begin
      if (strb_i[b]) begin
        mem[idx_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
      end
    end
  end

  // ====================
  // Registered read
  // ====================

  // Output register only loads on a strobe
  // so back-pressure in a burst leaves it stable
  always_ff @(posedge clk_i) begin
    if (rd_i) begin
      rdata_o <= mem[idx_i];
    end
  end

endmodule

`default_nettype wire

/* flist.f */
design/ram_wb_pkg.sv
design/ram_wb_ctrl.sv
design/ram_word_bank.sv
design/ram_line_reader.sv
design/ram_wb_top.sv
tb/ram_wb_checker.sv
tb/tb_ram_wb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the line RAM slave testbench with Verilator

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert \
  --top-module tb_ram_wb -Mdir "$OBJ" -f flist.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$OBJ/Vtb_ram_wb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Finished with errors" "$LOG"; then
  echo "Simulation reported failure"
  exit 1
fi
echo "Simulation passed"
exit 0

/* tb/ram_wb_checker.sv */
// ====================
// Bus monitor and reference model for the line RAM slave
// Samples on the falling edge, mid-cycle
// Model wraps addresses modulo MODEL_WORDS
// ====================
`timescale 1ns/1ps
`default_nettype none

module ram_wb_checker
  import ram_wb_pkg::*;
#(
  parameter int RAM_LATENCY = 16,
  parameter int MODEL_WORDS = 64
) (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      wb_cyc_i,
  input  logic      wb_stb_i,
  input  logic      wb_we_i,
  input  ram_addr_u wb_adr_i,
  input  word_t     wb_dat_i,
  input  strb_t     wb_sel_i,
  input  cti_t      wb_cti_i,
  input  word_t     dut_dat_i,
  input  logic      dut_ack_i,
  output int        data_err_o,
  output int        timing_err_o,
  output int        ack_cnt_o
);

  localparam int IDX_W = $clog2(MODEL_WORDS);

  word_t            model [MODEL_WORDS];
  logic [IDX_W-1:0] idx;
  logic             req;
  // Request seen but not yet acknowledged
  logic             in_req;
  // Set by an INCR first beat, cleared by EOB
  logic             burst_open;
  int               cyc_n;
  int               start_n;
  int               exp_lat;

  // Old bytes kept where sel is low
  function automatic word_t merge_bytes(input word_t old_w, input word_t new_w,
                                        input strb_t sel);
    merge_bytes = old_w;
    for (int b = 0; b < 4; b++) begin
      if (sel[b]) begin
        merge_bytes[b*8 +: 8] = new_w[b*8 +: 8];
      end
    end
  endfunction

  initial begin
    data_err_o = 0;
    timing_err_o = 0;
    ack_cnt_o = 0;
    for (int i = 0; i < MODEL_WORDS; i++) begin
      model[i] = '0;
    end
  end

  // ====================
  // Monitor
  // ====================
  always @(negedge clk_i) begin
    if (!rst_ni) begin
      in_req = 1'b0;
      burst_open = 1'b0;
      cyc_n = 0;
    end else begin
      cyc_n = cyc_n + 1;
      req = wb_cyc_i && wb_stb_i;
      idx = wb_adr_i.byte_addr[IDX_W+1:2];
      // Writes and buffered beats are immediate
      if (req && !in_req) begin
        in_req = 1'b1;
        start_n = cyc_n;
        exp_lat = (wb_we_i || burst_open) ? 0 : RAM_LATENCY;
      end
      if ($isunknown(dut_ack_i)) begin
        timing_err_o = timing_err_o + 1;
        $display("Error at time %0t: ack is unknown after reset", $time);
      end else if (dut_ack_i && !req) begin
        // Covers idle gaps and the quiet bus after reset
        timing_err_o = timing_err_o + 1;
        $display("Error at time %0t: ack without a request", $time);
      end else if (dut_ack_i) begin
        ack_cnt_o = ack_cnt_o + 1;
        if (cyc_n - start_n != exp_lat) begin
          timing_err_o = timing_err_o + 1;
          $display("Error at time %0t: ack after %0d cycles, expected %0d",
                   $time, cyc_n - start_n, exp_lat);
        end
        if (wb_we_i) begin
          model[idx] = merge_bytes(model[idx], wb_dat_i, wb_sel_i);
        end else begin
          if (dut_dat_i !== model[idx]) begin
            data_err_o = data_err_o + 1;
            $display("Error at time %0t: read word %0d gave 0x%h, expected 0x%h",
                     $time, idx, dut_dat_i, model[idx]);
          end
          if (!burst_open && wb_cti_i == CTI_INCR) begin
            burst_open = 1'b1;
          end else if (burst_open && wb_cti_i == CTI_EOB) begin
            burst_open = 1'b0;
          end
        end
        in_req = 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

/* tb/tb_ram_wb.sv */
// ====================
// Testbench top for the Wishbone line RAM slave
// Fills all 64 words, then runs 400 random writes, reads and bursts
// Bursts stay inside one line, 2 to 4 beats, with random stb gaps
// ====================
`timescale 1ns/1ps
`default_nettype none

module tb_ram_wb
  import ram_wb_pkg::*;
;

  localparam int LINE_DEPTH     = 16;
  localparam int RAM_LATENCY    = 5;
  localparam int RESET_CYCLES   = 16;
  localparam int FILL_WORDS     = 64;
  localparam int TXN_COUNT      = 400;
  // Worst case per transaction plus fill and reset
  localparam int TIMEOUT_CYCLES = TXN_COUNT * 4 * (RAM_LATENCY + 8)
                                  + RESET_CYCLES + FILL_WORDS * 2;

  logic      clk;
  logic      rst_n;
  logic      wb_cyc;
  logic      wb_stb;
  logic      wb_we;
  ram_addr_u wb_adr;
  word_t     wb_dat;
  strb_t     wb_sel;
  cti_t      wb_cti;
  word_t     wb_dat_rd;
  logic      wb_ack;
  int        data_errs;
  int        timing_errs;
  int        ack_cnt;
  int        cycles;
  logic [15:0] lfsr;

  ram_wb_top #(
    .LINE_DEPTH  (LINE_DEPTH),
    .RAM_LATENCY (RAM_LATENCY)
  ) uut (
    .clk_i    (clk),
    .rst_ni   (rst_n),
    .wb_cyc_i (wb_cyc),
    .wb_stb_i (wb_stb),
    .wb_we_i  (wb_we),
    .wb_adr_i (wb_adr),
    .wb_dat_i (wb_dat),
    .wb_sel_i (wb_sel),
    .wb_cti_i (wb_cti),
    .wb_dat_o (wb_dat_rd),
    .wb_ack_o (wb_ack)
  );

  ram_wb_checker #(
    .RAM_LATENCY (RAM_LATENCY),
    .MODEL_WORDS (LINE_DEPTH * LINE_WORDS)
  ) u_checker (
    .clk_i        (clk),
    .rst_ni       (rst_n),
    .wb_cyc_i     (wb_cyc),
    .wb_stb_i     (wb_stb),
    .wb_we_i      (wb_we),
    .wb_adr_i     (wb_adr),
    .wb_dat_i     (wb_dat),
    .wb_sel_i     (wb_sel),
    .wb_cti_i     (wb_cti),
    .dut_dat_i    (wb_dat_rd),
    .dut_ack_i    (wb_ack),
    .data_err_o   (data_errs),
    .timing_err_o (timing_errs),
    .ack_cnt_o    (ack_cnt)
  );

  // ====================
  // Clock and timeout
  // ====================
  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Finished with errors");
      $finish;
    end
  end

  // ====================
  // Random source
  // ====================

  // 16-bit Galois LFSR, taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    lfsr_step = {1'b0, s[15:1]} ^ (s[0] ? 16'hB400 : 16'h0000);
  endfunction

  // One LFSR step per bit taken
  task automatic rand_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v = {v[30:0], lfsr[0]};
    end
  endtask

  // Fill data mixes every address bit
  function automatic word_t fill_word(input logic [31:0] addr);
    fill_word = (addr * 32'h9E3779B1) ^ 32'hA5A5_0F0F;
  endfunction

  // ====================
  // Bus driver
  // ====================
  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  // Ack sampled mid-cycle, then step to the next drive point
  task automatic wait_ack();
    logic seen;
    seen = 1'b0;
    while (!seen) begin
      @(negedge clk);
      seen = wb_ack;
    end
    next_cycle();
  endtask

  task automatic bus_beat(input logic we, input logic [31:0] addr, input word_t data,
                          input strb_t sel, input cti_t cti);
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we = we;
    wb_adr.byte_addr = addr;
    wb_dat = data;
    wb_sel = sel;
    wb_cti = cti;
    wait_ack();
  endtask

  task automatic bus_release();
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
    wb_cti = CTI_CLASSIC;
  endtask

  // INCR beats then one EOB beat, all in one line
  task automatic run_burst();
    logic [31:0] r;
    logic [31:0] line_no;
    int beats;
    int start;
    rand_bits(12, line_no);
    rand_bits(4, r);
    beats = 2 + (int'(r) % 3);
    rand_bits(2, r);
    start = int'(r) % (5 - beats);
    for (int k = 0; k < beats; k++) begin
      bus_beat(1'b0, {line_no[27:0], 2'(start + k), 2'b00}, '0, 4'hF,
               (k == beats - 1) ? CTI_EOB : CTI_INCR);
      if (k != beats - 1) begin
        // Idle gap with cyc held
        wb_stb = 1'b0;
        rand_bits(2, r);
        repeat (int'(r)) next_cycle();
      end
    end
  endtask

  initial begin
    logic [31:0] r;
    logic [31:0] addr;
    logic [31:0] data;
    clk = 1'b0;
    rst_n = 1'b0;
    cycles = 0;
    lfsr = 16'd8354;
    wb_adr.byte_addr = '0;
    wb_dat = '0;
    wb_sel = '0;
    bus_release();
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst_n = 1'b1;
    // Quiet bus first, ack must stay low
    repeat (4) next_cycle();

    for (int w = 0; w < FILL_WORDS; w++) begin
      bus_beat(1'b1, 32'(w) << 2, fill_word(32'(w) << 2), 4'hF, CTI_CLASSIC);
    end
    bus_release();
    next_cycle();

    for (int t = 0; t < TXN_COUNT; t++) begin
      rand_bits(2, r);
      if (r == 0) begin
        rand_bits(12, addr);
        rand_bits(32, data);
        rand_bits(4, r);
        bus_beat(1'b1, {addr[29:0], 2'b00}, data, r[3:0], CTI_CLASSIC);
      end else if (r == 1) begin
        rand_bits(12, addr);
        bus_beat(1'b0, {addr[29:0], 2'b00}, '0, 4'hF, CTI_CLASSIC);
      end else begin
        run_burst();
      end
      bus_release();
      rand_bits(1, r);
      repeat (int'(r)) next_cycle();
    end

    repeat (4) next_cycle();
    $display("Summary: %0d acks, %0d data errors, %0d timing errors",
             ack_cnt, data_errs, timing_errs);
    if (data_errs == 0 && timing_errs == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire
